//--- design/router_pkg.sv
`default_nettype none

package router_pkg;

    // number of output ports, address 3 is unused.
    localparam int NUM_PORTS = 3;

    typedef logic [7:0] byte_t;

    // header marker in bit 8, data byte below it.
    typedef logic [8:0] fifo_word_t;

    typedef logic [1:0] port_addr_t;

    typedef logic [5:0] pkt_len_t;

    // input side packet FSM.
    typedef enum logic [2:0] {
        st_decode,
        st_load_first,
        st_load_data,
        st_wait_full,
        st_load_parity,
        st_check_parity,
        st_wait_empty
    } in_state_t;

endpackage

`default_nettype wire

//--- design/router_input_fsm.sv
`default_nettype none

module router_input_fsm
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pkt_valid,
    input  byte_t data_in,
    input  logic  fifo_full,
    output logic  busy,
    output logic  err,
    output logic  detect_add,
    output logic  write_enb_reg,
    output logic  lfd_state,
    output byte_t fifo_byte
);

    in_state_t state;
    in_state_t state_nxt;
    byte_t     parity_int;
    byte_t     parity_rx;
    logic      take;
    logic      wr_stall;

    // the registered byte could not go into the fifo this cycle.
    assign wr_stall = write_enb_reg && fifo_full;

    assign detect_add = (state == st_decode) && pkt_valid; // header sits on data_in.

    always_comb begin
        case (state)
            st_decode:       busy = pkt_valid && fifo_full;
            st_load_data,
            st_wait_full:    busy = fifo_full; // back-pressure.
            default:         busy = 1'b1;
        endcase
    end

    // a byte is taken at this edge. with pkt_valid low in the data states it is parity.
    assign take = !busy && (detect_add || state == st_load_data || state == st_wait_full);

    always_comb begin
        state_nxt = state;
        case (state)
            st_decode: begin
                if (pkt_valid) begin
                    state_nxt = fifo_full ? st_wait_empty : st_load_first;
                end
            end
            st_wait_empty: begin
                if (!fifo_full) begin
                    state_nxt = st_decode;
                end
            end
            st_load_first: begin
                if (!wr_stall) begin
                    state_nxt = st_load_data;
                end
            end
            st_load_data: begin
                if (fifo_full) begin
                    state_nxt = st_wait_full;
                end else if (!pkt_valid) begin
                    state_nxt = st_load_parity;
                end
            end
            st_wait_full: begin
                if (!fifo_full) begin
                    state_nxt = pkt_valid ? st_load_data : st_load_parity;
                end
            end
            st_load_parity: begin
                if (!wr_stall) begin // parity must be stored before the check.
                    state_nxt = st_check_parity;
                end
            end
            st_check_parity: state_nxt = st_decode;
            default:         state_nxt = st_decode;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= st_decode;
            write_enb_reg <= 1'b0;
            err           <= 1'b0;
        end else begin
            state <= state_nxt;
            err   <= (state == st_check_parity) && (parity_int != parity_rx);
            if (take) begin
                write_enb_reg <= 1'b1;
            end else if (!wr_stall) begin
                write_enb_reg <= 1'b0; // keep the strobe up while parked.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fifo_byte <= data_in;
            lfd_state <= detect_add;
        end
        if (take && detect_add) begin
            parity_int <= data_in; // parity starts with the header.
        end else if (take && pkt_valid) begin
            parity_int <= parity_int ^ data_in;
        end else if (take) begin
            parity_rx <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- design/router_sync.sv
`default_nettype none

module router_sync
    import router_pkg::*;
#(
    parameter int SOFT_RESET_CYCLES = 30
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  detect_add,
    input  logic  write_enb_reg,
    input  byte_t data_in,
    input  logic  full_0,
    input  logic  full_1,
    input  logic  full_2,
    input  logic  empty_0,
    input  logic  empty_1,
    input  logic  empty_2,
    input  logic  read_enb_0,
    input  logic  read_enb_1,
    input  logic  read_enb_2,
    output logic  write_enb_0,
    output logic  write_enb_1,
    output logic  write_enb_2,
    output logic  fifo_full,
    output logic  soft_rst_0,
    output logic  soft_rst_1,
    output logic  soft_rst_2,
    output logic  valid_out_0,
    output logic  valid_out_1,
    output logic  valid_out_2
);

    localparam int NUM_ADDR = 2 ** $bits(port_addr_t);
    localparam int TW       = $clog2(SOFT_RESET_CYCLES + 1);

    port_addr_t           addr_q;
    port_addr_t           addr_sel;
    logic [NUM_PORTS-1:0] full_v;
    logic [NUM_PORTS-1:0] valid_v;
    logic [NUM_PORTS-1:0] rd_v;
    logic [NUM_PORTS-1:0] wr_v;
    logic [NUM_PORTS-1:0] srst_v;
    logic [NUM_ADDR-1:0]  full_pad;

    assign full_v  = {full_2, full_1, full_0};
    assign valid_v = ~{empty_2, empty_1, empty_0};
    assign rd_v    = {read_enb_2, read_enb_1, read_enb_0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (detect_add) begin
            addr_q <= data_in[1:0];
        end
    end

    // during decode the header on data_in is not latched yet.
    assign addr_sel  = detect_add ? data_in[1:0] : addr_q;
    assign full_pad  = NUM_ADDR'(full_v); // address 3 is never full.
    assign fifo_full = full_pad[addr_sel];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        logic [TW-1:0] idle_cnt;

        assign wr_v[i] = write_enb_reg && (addr_q == port_addr_t'(i));

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                idle_cnt  <= '0;
                srst_v[i] <= 1'b0;
            end else begin
                srst_v[i] <= 1'b0;
                if (rd_v[i] || !valid_v[i]) begin
                    idle_cnt <= '0;
                end else if (idle_cnt == TW'(SOFT_RESET_CYCLES - 1)) begin
                    idle_cnt  <= '0;
                    srst_v[i] <= 1'b1; // nobody read this port in time.
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    assign {write_enb_2, write_enb_1, write_enb_0} = wr_v;
    assign {soft_rst_2, soft_rst_1, soft_rst_0}    = srst_v;
    assign {valid_out_2, valid_out_1, valid_out_0} = valid_v;

endmodule

`default_nettype wire

//--- design/router_fifo.sv
`default_nettype none

module router_fifo
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  soft_rst,
    input  logic  write_enb,
    input  logic  read_enb,
    input  logic  lfd_state,
    input  byte_t data_in,
    output logic  full,
    output logic  empty,
    output byte_t data_out
);

    localparam int PW = $clog2(FIFO_DEPTH);

    fifo_word_t                mem [FIFO_DEPTH];
    logic [PW-1:0]             wr_ptr;
    logic [PW-1:0]             rd_ptr;
    logic [PW:0]               count;
    logic [$bits(pkt_len_t):0] byte_cnt; // bytes left in the packet being read.
    fifo_word_t                rd_word;
    pkt_len_t                  rd_len;
    logic                      do_wr;
    logic                      do_rd;

    assign full  = (count == (PW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = write_enb && !full;
    assign do_rd = read_enb && !empty;

    assign rd_word = mem[rd_ptr];
    assign rd_len  = rd_word[7:2];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= {lfd_state, data_in};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || soft_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none, or read and write together.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || soft_rst) begin
            data_out <= '0;
            byte_cnt <= '0;
        end else if (read_enb) begin
            if (do_rd && rd_word[8]) begin
                data_out <= rd_word[7:0];
                byte_cnt <= {1'b0, rd_len} + 1'b1; // payload plus parity.
            end else if (do_rd && byte_cnt != '0) begin
                data_out <= rd_word[7:0];
                byte_cnt <= byte_cnt - 1'b1;
            end else if (byte_cnt == '0) begin
                data_out <= '0; // past the end of the packet.
            end
        end
    end

endmodule

`default_nettype wire

//--- design/router_top.sv
`default_nettype none

module router_top
    import router_pkg::*;
#(
    parameter int FIFO_DEPTH        = 16,
    parameter int SOFT_RESET_CYCLES = 30
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pkt_valid,
    input  byte_t data_in,
    input  logic  read_enb_0,
    input  logic  read_enb_1,
    input  logic  read_enb_2,
    output logic  busy,
    output logic  err,
    output byte_t data_out_0,
    output byte_t data_out_1,
    output byte_t data_out_2,
    output logic  valid_out_0,
    output logic  valid_out_1,
    output logic  valid_out_2
);

    logic                 detect_add;
    logic                 write_enb_reg;
    logic                 lfd_state;
    logic                 fifo_full;
    byte_t                fifo_byte;
    logic [NUM_PORTS-1:0] write_enb;
    logic [NUM_PORTS-1:0] soft_rst;
    logic [NUM_PORTS-1:0] full;
    logic [NUM_PORTS-1:0] empty;

    router_input_fsm i_input_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .pkt_valid     (pkt_valid),
        .data_in       (data_in),
        .fifo_full     (fifo_full),
        .busy          (busy),
        .err           (err),
        .detect_add    (detect_add),
        .write_enb_reg (write_enb_reg),
        .lfd_state     (lfd_state),
        .fifo_byte     (fifo_byte)
    );

    router_sync #(
        .SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
    ) i_sync (
        .clk           (clk),
        .rst_n         (rst_n),
        .detect_add    (detect_add),
        .write_enb_reg (write_enb_reg),
        .data_in       (data_in),
        .full_0        (full[0]),
        .full_1        (full[1]),
        .full_2        (full[2]),
        .empty_0       (empty[0]),
        .empty_1       (empty[1]),
        .empty_2       (empty[2]),
        .read_enb_0    (read_enb_0),
        .read_enb_1    (read_enb_1),
        .read_enb_2    (read_enb_2),
        .write_enb_0   (write_enb[0]),
        .write_enb_1   (write_enb[1]),
        .write_enb_2   (write_enb[2]),
        .fifo_full     (fifo_full),
        .soft_rst_0    (soft_rst[0]),
        .soft_rst_1    (soft_rst[1]),
        .soft_rst_2    (soft_rst[2]),
        .valid_out_0   (valid_out_0),
        .valid_out_1   (valid_out_1),
        .valid_out_2   (valid_out_2)
    );

    router_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .soft_rst  (soft_rst[0]),
        .write_enb (write_enb[0]),
        .read_enb  (read_enb_0),
        .lfd_state (lfd_state),
        .data_in   (fifo_byte),
        .full      (full[0]),
        .empty     (empty[0]),
        .data_out  (data_out_0)
    );

    router_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .soft_rst  (soft_rst[1]),
        .write_enb (write_enb[1]),
        .read_enb  (read_enb_1),
        .lfd_state (lfd_state),
        .data_in   (fifo_byte),
        .full      (full[1]),
        .empty     (empty[1]),
        .data_out  (data_out_1)
    );

    router_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .soft_rst  (soft_rst[2]),
        .write_enb (write_enb[2]),
        .read_enb  (read_enb_2),
        .lfd_state (lfd_state),
        .data_in   (fifo_byte),
        .full      (full[2]),
        .empty     (empty[2]),
        .data_out  (data_out_2)
    );

endmodule

`default_nettype wire

//--- test/router_properties.sv
`default_nettype none

module router_properties
    import router_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 err,
    input wire logic [NUM_PORTS-1:0] valid_out,
    input wire logic [NUM_PORTS-1:0] soft_rst
);

    // err is a single-cycle pulse.
    err_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) err |=> !err)
        else $error("err stayed high for more than one cycle");

    no_valid_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (valid_out == '0) ##1 (valid_out == '0)
    ) else $error("valid_out rose right after reset");

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        soft_rst_clears: assert property (
            @(posedge clk) disable iff (!rst_n) soft_rst[i] |=> !valid_out[i]
        ) else $error("valid_out %0d still high after its soft reset", i);
    end

endmodule

bind router_top router_properties i_router_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .err       (err),
    .valid_out ({valid_out_2, valid_out_1, valid_out_0}),
    .soft_rst  (soft_rst)
);

`default_nettype wire

//--- test/router_tb.sv
`default_nettype none

module router_tb
    import router_pkg::*;
;

    localparam int FIFO_DEPTH        = 16;
    localparam int SOFT_RESET_CYCLES = 30;
    localparam int TIMEOUT_CYCLES    = 4000; // roughly five times the full sequence.

    logic                 clk;
    logic                 rst_n;
    logic                 pkt_valid;
    byte_t                data_in;
    logic [NUM_PORTS-1:0] rd_enb;
    logic                 busy;
    logic                 err;
    byte_t                dout [NUM_PORTS];
    logic [NUM_PORTS-1:0] valid_v;

    byte_t                exp_q [NUM_PORTS][$]; // expected bytes per port.
    logic [NUM_PORTS-1:0] rd_on;
    logic [NUM_PORTS-1:0] pop_pend;
    logic                 rd_rand;
    logic                 err_due;
    int                   cyc;
    int                   par_edge;
    int                   seed;
    string                test_name;

    router_top #(
        .FIFO_DEPTH        (FIFO_DEPTH),
        .SOFT_RESET_CYCLES (SOFT_RESET_CYCLES)
    ) i_router_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .pkt_valid   (pkt_valid),
        .data_in     (data_in),
        .read_enb_0  (rd_enb[0]),
        .read_enb_1  (rd_enb[1]),
        .read_enb_2  (rd_enb[2]),
        .busy        (busy),
        .err         (err),
        .data_out_0  (dout[0]),
        .data_out_1  (dout[1]),
        .data_out_2  (dout[2]),
        .valid_out_0 (valid_v[0]),
        .valid_out_1 (valid_v[1]),
        .valid_out_2 (valid_v[2])
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cyc      <= cyc + 1;
        pop_pend <= rd_enb & valid_v; // a word leaves the fifo at this edge.
        if (cyc >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout in %s, the DUT stopped making progress", test_name));
        end
    end

    // read enables, steady or coin-flip per port.
    always @(negedge clk) begin : drive_reads
        logic coin;
        for (int n = 0; n < NUM_PORTS; n++) begin
            coin      = 1'($random(seed));
            rd_enb[n] = rst_n && rd_on[n] && (!rd_rand || coin);
        end
    end

    always @(negedge clk) begin : check_outputs
        byte_t exp_byte;
        logic  exp_err;
        for (int n = 0; n < NUM_PORTS; n++) begin
            if (pop_pend[n]) begin
                assert (exp_q[n].size() > 0)
                    else stop_on_error($sformatf("%s: port %0d delivered a byte nobody sent",
                                                 test_name, n));
                exp_byte = exp_q[n].pop_front();
                assert (dout[n] == exp_byte)
                    else stop_on_error($sformatf("ERROR %s: port %0d expected %h, actual %h",
                                                 test_name, n, exp_byte, dout[n]));
            end
        end
        exp_err = err_due && (cyc == par_edge + 2);
        if (rst_n) begin
            assert (err == exp_err)
                else stop_on_error($sformatf("ERROR %s: err expected %b, actual %b",
                                             test_name, exp_err, err));
        end
    end

    task automatic drive_byte(input byte_t b, input logic last);
        @(negedge clk);
        pkt_valid = !last; // parity goes out with pkt_valid low.
        data_in   = b;
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic send_packet(input port_addr_t addr, input pkt_len_t len, input logic corrupt);
        byte_t hdr;
        byte_t par;
        byte_t b;
        byte_t pay [$];
        hdr = {len, addr};
        par = hdr;
        for (int i = 0; i < int'(len); i++) begin
            b = byte_t'($random(seed));
            pay.push_back(b);
            par = par ^ b;
        end
        if (corrupt) begin
            par = ~par;
        end
        if (int'(addr) < NUM_PORTS) begin
            exp_q[addr].push_back(hdr);
            foreach (pay[i]) exp_q[addr].push_back(pay[i]);
            exp_q[addr].push_back(par);
        end
        drive_byte(hdr, 1'b0);
        foreach (pay[i]) drive_byte(pay[i], 1'b0);
        drive_byte(par, 1'b1);
        par_edge = cyc + 1;
        err_due  = corrupt;
        @(negedge clk);
        data_in = '0;
    endtask

    // wait until every expected byte has come out.
    task automatic drain_ports();
        do begin
            @(negedge clk);
        end while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0
                   || valid_v != '0 || pop_pend != '0);
    endtask

    initial begin
        int rise_cyc;
        seed      = 32'h8324_add6;
        rst_n     = 1'b0;
        pkt_valid = 1'b0;
        data_in   = '0;
        rd_enb    = '0;
        rd_on     = '1;
        rd_rand   = 1'b0;
        err_due   = 1'b0;
        cyc       = 0;
        par_edge  = -10;
        rise_cyc  = 0;
        test_name = "reset";
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!busy && !err && valid_v == '0)
            else stop_on_error("outputs are not idle after reset");

        test_name = "basic";
        send_packet(2'd0, 6'd5, 1'b0);
        send_packet(2'd1, 6'd9, 1'b0);
        send_packet(2'd2, 6'd14, 1'b0);
        drain_ports();

        test_name = "parity";
        send_packet(2'd1, 6'd7, 1'b0);
        send_packet(2'd0, 6'd11, 1'b1);
        drain_ports();

        test_name = "bad_addr";
        send_packet(2'd3, 6'd6, 1'b0);
        repeat (4) @(negedge clk);
        assert (valid_v == '0) else stop_on_error("a packet to address 3 reached a port");

        test_name = "backpressure";
        rd_on[1] = 1'b0;
        fork
            send_packet(2'd1, 6'd40, 1'b0);
            begin : wait_full
                int busy_run;
                busy_run = 0;
                // three busy cycles in a row only happen on a full fifo.
                while (busy_run < 3) begin
                    @(negedge clk);
                    busy_run = busy ? busy_run + 1 : 0;
                end
                rd_on[1] = 1'b1;
            end
        join
        drain_ports();

        test_name = "soft_reset";
        rd_on[2] = 1'b0;
        fork
            send_packet(2'd2, 6'd6, 1'b0);
            begin
                do @(negedge clk); while (!valid_v[2]);
                rise_cyc = cyc;
            end
        join
        do @(negedge clk); while (valid_v[2]);
        // idle cycles counted, then one cycle of soft reset.
        assert (cyc - rise_cyc == SOFT_RESET_CYCLES + 1)
            else stop_on_error($sformatf("ERROR %s: port 2 flushed after expected %0d, actual %0d",
                                         test_name, SOFT_RESET_CYCLES + 1, cyc - rise_cyc));
        exp_q[2].delete();
        rd_on[2] = 1'b1;
        send_packet(2'd2, 6'd9, 1'b0);
        drain_ports();

        test_name = "interleave";
        rd_on = 3'b100;
        send_packet(2'd0, 6'd8, 1'b0);
        send_packet(2'd1, 6'd8, 1'b0);
        rd_rand = 1'b1;
        rd_on   = '1;
        send_packet(2'd0, 6'd12, 1'b0);
        send_packet(2'd1, 6'd10, 1'b1);
        drain_ports();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/router_pkg.sv
design/router_input_fsm.sv
design/router_sync.sv
design/router_fifo.sv
design/router_top.sv
test/router_properties.sv
test/router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the router testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module router_tb \
    -Mdir obj_dir -o router_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/router_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
